// ==== common/client_pkg.sv ====
// Shared definitions for the packet client hub
// Client count, bank geometry, header layout, reply latency and the enums

package client_pkg;

	// Four identical register clients behind the hub
	localparam int N_CLIENTS = 4;
	localparam int CLIENT_W  = $clog2(N_CLIENTS);  // Width of a client index

	// Per-client register bank
	localparam int BANK_DEPTH = 16;                   // Bytes per bank
	localparam int ADDR_W     = $clog2(BANK_DEPTH);   // Low bits of the address byte

	// Payload header is id, opcode, start address
	localparam int HDR_LEN = 3;

	// len_c runs 8 above the remaining byte count
	// Smallest legal len_c on byte 0 leaves room for one data byte
	localparam int MIN_LEN = 8 + HDR_LEN + 1;

	// Edges from an accepted byte to its reply on odata
	localparam int LAT = 3;

	// Opcodes carried in header byte 1
	typedef enum logic [7:0] {
		OP_ECHO  = 8'd0,  // Reply with the data byte
		OP_READ  = 8'd1,  // Reply with bank contents
		OP_WRITE = 8'd2   // Reply with old contents, store new byte
	} op_t;

	// Steer position within a payload
	typedef enum logic [1:0] {
		ST_ID   = 2'd0,   // Next byte is the client id (or bus idle)
		ST_OP   = 2'd1,   // Next byte is the opcode
		ST_ADDR = 2'd2,   // Next byte is the start address
		ST_DATA = 2'd3    // Data bytes until the window closes
	} steer_state_t;

endpackage

// ==== common/client_if.sv ====
// Byte stream from the steer to one register client, and its reply
// Steer drives the request side, merge reads the reply
`timescale 1ns/1ps

interface client_if;

	logic strobe;                             // Data byte for this client
	logic first;                              // First data byte of the packet
	logic [7:0] data;                         // The data byte
	client_pkg::op_t op;                      // Opcode latched from the header
	logic [client_pkg::ADDR_W-1:0] addr;      // Start address from the header
	logic [7:0] reply;                        // Reply byte, one clock later

	modport steer (
		output strobe, first, data, op, addr
	);

	modport client (
		input strobe, first, data, op, addr,
		output reply
	);

	// Merge only collects replies
	modport merge (
		input reply
	);

endinterface

// ==== rtl/client_steer.sv ====
// Header parser and fan-out for the client hub
// Checks id and length on byte 0, routes data bytes to one client
`timescale 1ns/1ps

module client_steer (
	input clk,
	input reset,
	input [10:0] len_c,
	input [7:0] idata,
	input raw_l,
	input raw_s,
	output logic hdr_valid,
	output [7:0] hdr_data,
	client_if.steer clients [client_pkg::N_CLIENTS]
);

	client_pkg::steer_state_t state;
	logic acc;                                       // Byte accepted this edge
	logic [client_pkg::CLIENT_W-1:0] id_q;           // Target client
	logic rej_q;                                     // Bad id or short packet
	client_pkg::op_t op_q;
	logic [client_pkg::ADDR_W-1:0] addr_q;
	logic first_pend;                                // Next data byte is the first
	logic [7:0] byte_q;                              // Byte registered for all sinks
	logic first_q;
	logic [client_pkg::N_CLIENTS-1:0] strobe_q;

	// Bytes outside the packet window do not count
	assign acc = raw_s & raw_l;

	// State falls back to ST_ID on any cycle without a byte
	// so ST_ID together with acc marks a packet start
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= client_pkg::ST_ID;
		end else if (!acc) begin
			state <= client_pkg::ST_ID;
		end else begin
			case (state)
				client_pkg::ST_ID:   state <= client_pkg::ST_OP;
				client_pkg::ST_OP:   state <= client_pkg::ST_ADDR;
				client_pkg::ST_ADDR: state <= client_pkg::ST_DATA;
				default:             state <= client_pkg::ST_DATA;  // Stay until idle
			endcase
		end
	end

	// Header fields, held through the data phase
	always_ff @(posedge clk) begin
		if (acc && state == client_pkg::ST_ID) begin
			id_q <= idata[client_pkg::CLIENT_W-1:0];
		end
		if (acc && state == client_pkg::ST_OP) op_q <= client_pkg::op_t'(idata);
		if (acc && state == client_pkg::ST_ADDR) addr_q <= idata[client_pkg::ADDR_W-1:0];
		byte_q <= idata;  // Same byte feeds header echo and client data
	end

	// Reject flag and data-phase control
	always_ff @(posedge clk) begin
		if (reset) begin
			rej_q <= 1'b1;
			first_pend <= 1'b0;
			first_q <= 1'b0;
			strobe_q <= '0;
			hdr_valid <= 1'b0;
		end else begin
			if (acc && state == client_pkg::ST_ID) begin
				// Full id byte and length checked on byte 0
				rej_q <= (idata >= 8'(client_pkg::N_CLIENTS)) ||
					(len_c < 11'(client_pkg::MIN_LEN));
			end
			if (acc && state == client_pkg::ST_ADDR) first_pend <= 1'b1;
			else if (acc && state == client_pkg::ST_DATA) first_pend <= 1'b0;
			hdr_valid <= acc && state != client_pkg::ST_DATA;
			first_q <= first_pend;
			strobe_q <= '0;
			if (acc && state == client_pkg::ST_DATA && !rej_q) begin
				strobe_q[id_q] <= 1'b1;  // One-hot toward the addressed client
			end
		end
	end

	assign hdr_data = byte_q;

	// Fan out to every client, only the strobe differs
	for (genvar i = 0; i < client_pkg::N_CLIENTS; i++) begin : g_fan
		assign clients[i].strobe = strobe_q[i];
		assign clients[i].first = first_q;
		assign clients[i].data = byte_q;
		assign clients[i].op = op_q;
		assign clients[i].addr = addr_q;
	end

endmodule

// ==== reg_client/reg_client.sv ====
// Register client with a 16-byte bank
// Executes READ, WRITE and ECHO on the data bytes steered to it
`timescale 1ns/1ps

module reg_client (
	input clk,
	input reset,
	client_if.client port
);

	logic [7:0] bank [client_pkg::BANK_DEPTH];
	logic [client_pkg::ADDR_W-1:0] ptr;       // Position for the next data byte
	logic [client_pkg::ADDR_W-1:0] cur;       // Position used by this byte
	logic [7:0] rd_byte;
	logic [7:0] reply_d;

	// First data byte starts at the header address
	assign cur = port.first ? port.addr : ptr;
	assign rd_byte = bank[cur];

	// Reply selection per opcode
	always_comb begin
		case (port.op)
			client_pkg::OP_READ:  reply_d = rd_byte;
			client_pkg::OP_WRITE: reply_d = rd_byte;    // Old contents go back
			client_pkg::OP_ECHO:  reply_d = port.data;
			default:              reply_d = 8'h00;      // Unknown opcode
		endcase
	end

	// Bank starts cleared, written only by WRITE
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < client_pkg::BANK_DEPTH; i++) begin
				bank[i] <= 8'h00;
			end
		end else if (port.strobe && port.op == client_pkg::OP_WRITE) begin
			bank[cur] <= port.data;
		end
	end

	// Pointer wraps naturally at BANK_DEPTH
	always_ff @(posedge clk) begin
		if (reset) begin
			ptr <= '0;
		end else if (port.strobe) begin
			ptr <= cur + 1'b1;
		end
	end

	// Quiet when not addressed, so the merge can OR
	always_ff @(posedge clk) begin
		if (reset) begin
			port.reply <= 8'h00;
		end else if (port.strobe) begin
			port.reply <= reply_d;
		end else begin
			port.reply <= 8'h00;
		end
	end

endmodule

// ==== rtl/reply_merge.sv ====
// Reply merge for the client hub
// Lines the header echo up with client replies and registers odata
`timescale 1ns/1ps

module reply_merge (
	input clk,
	input reset,
	input hdr_valid,
	input [7:0] hdr_data,
	client_if.merge clients [client_pkg::N_CLIENTS],
	output logic [7:0] odata
);

	logic [7:0] hdr_echo;                                 // Header byte, one stage late
	logic [7:0] replies [client_pkg::N_CLIENTS];
	logic [7:0] merged;

	// Same stage as the client reply registers
	always_ff @(posedge clk) begin
		if (reset) hdr_echo <= 8'h00;
		else hdr_echo <= hdr_valid ? hdr_data : 8'h00;
	end

	// Gather replies out of the interface array
	for (genvar i = 0; i < client_pkg::N_CLIENTS; i++) begin : g_rep
		assign replies[i] = clients[i].reply;
	end

	// At most one source is nonzero for any byte
	always_comb begin
		merged = hdr_echo;
		for (int i = 0; i < client_pkg::N_CLIENTS; i++) begin
			merged = merged | replies[i];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) odata <= 8'h00;
		else odata <= merged;
	end

endmodule

// ==== rtl/client_hub.sv ====
// Packet client hub top level
// Steers payload bytes to four register clients and merges replies onto odata
`timescale 1ns/1ps

module client_hub (
	input clk,
	input reset,
	input [10:0] len_c,     // Remaining length plus 8
	input [7:0] idata,
	input raw_l,            // Packet window
	input raw_s,            // Payload byte strobe
	output [7:0] odata      // Reply, LAT clocks behind idata
);

	logic hdr_valid;
	logic [7:0] hdr_data;

	client_if cif [client_pkg::N_CLIENTS] ();

	client_steer u_steer (
		.clk(clk),
		.reset(reset),
		.len_c(len_c),
		.idata(idata),
		.raw_l(raw_l),
		.raw_s(raw_s),
		.hdr_valid(hdr_valid),
		.hdr_data(hdr_data),
		.clients(cif)
	);

	// One register client per interface
	for (genvar i = 0; i < client_pkg::N_CLIENTS; i++) begin : g_client
		reg_client u_client (
			.clk(clk),
			.reset(reset),
			.port(cif[i])
		);
	end

	reply_merge u_merge (
		.clk(clk),
		.reset(reset),
		.hdr_valid(hdr_valid),
		.hdr_data(hdr_data),
		.clients(cif),
		.odata(odata)
	);

endmodule

// ==== verif/client_hub_chk.sv ====
// Protocol assertions for the client hub
// Strobe exclusivity and idle-cycle replies on odata
`timescale 1ns/1ps

module client_hub_chk (
	input clk,
	input reset,
	input raw_l,
	input raw_s,
	input hdr_valid,
	input [client_pkg::N_CLIENTS-1:0] strobes,
	input [7:0] odata
);

	// Steer addresses one client at a time
	a_one_strobe: assert property (@(posedge clk) disable iff (reset) $onehot0(strobes))
		else $error("more than one client strobe high");

	// No byte in, zero out LAT edges later
	a_idle_zero: assert property (@(posedge clk) disable iff (reset)
		!(raw_s && raw_l) |-> ##(client_pkg::LAT) (odata == 8'h00))
		else $error("odata nonzero after an idle cycle");

	a_hdr_excl: assert property (@(posedge clk) disable iff (reset) !(hdr_valid && |strobes))
		else $error("header echo and client strobe together");

endmodule

bind client_hub client_hub_chk u_chk (
	.clk(clk),
	.reset(reset),
	.raw_l(raw_l),
	.raw_s(raw_s),
	.hdr_valid(hdr_valid),
	.strobes(u_steer.strobe_q),
	.odata(odata)
);

// ==== verif/client_hub_tb.sv ====
// Testbench for the packet client hub
// Streams packets, models the four banks, checks every odata byte
`timescale 1ns/1ps

module client_hub_tb;

	logic clk;
	logic reset;
	logic [10:0] len_c;
	logic [7:0] idata;
	logic raw_l;
	logic raw_s;
	wire [7:0] odata;

	logic [31:0] lfsr_state;
	logic [7:0] model_bank [client_pkg::N_CLIENTS][client_pkg::BANK_DEPTH];
	logic [3:0] model_ptr [client_pkg::N_CLIENTS];
	int pkt_pos;                     // Byte index within the current packet
	logic prev_acc;                  // Previous cycle carried a byte
	int pkt_id;
	logic [7:0] pkt_op;
	logic [3:0] pkt_addr;
	logic pkt_rej;
	logic [7:0] pkt_data [64];       // Data bytes of the next packet
	logic [7:0] exp_q [$];           // Expected odata per driven cycle
	int stamp_q [$];                 // Edge count when that cycle was driven
	int cyc = 0;
	logic [7:0] exp_byte;
	int pushed, compared, n_checks, errors, n_tests, test_checks, test_errors;

	client_hub UUT (
		.clk(clk),
		.reset(reset),
		.len_c(len_c),
		.idata(idata),
		.raw_l(raw_l),
		.raw_s(raw_s),
		.odata(odata)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;           // 100 ns period

	always @(posedge clk) cyc <= cyc + 1;  // Rising edges seen so far

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) v = (v << 1) | lfsr_bit();  // One step per bit
		return v;
	endfunction

	// Expected reply for one driven cycle, updates the bank model
	function automatic logic [7:0] ref_reply(input logic acc, input logic [10:0] len,
			input logic [7:0] d);
		logic [3:0] a;
		logic [7:0] r;
		r = 8'h00;
		if (!acc) begin
			prev_acc = 1'b0;                        // Idle, next byte starts a packet
			return r;
		end
		if (!prev_acc) pkt_pos = 0;
		prev_acc = 1'b1;
		if (pkt_pos == 0) begin
			pkt_id = d;
			pkt_rej = (d >= client_pkg::N_CLIENTS) || (len < client_pkg::MIN_LEN);
			r = d;
		end else if (pkt_pos == 1) begin
			pkt_op = d;
			r = d;
		end else if (pkt_pos == 2) begin
			pkt_addr = d[3:0];
			r = d;
		end else if (!pkt_rej) begin
			a = (pkt_pos == 3) ? pkt_addr : model_ptr[pkt_id];  // First data byte loads addr
			case (pkt_op)
				client_pkg::OP_READ: r = model_bank[pkt_id][a];
				client_pkg::OP_WRITE: begin
					r = model_bank[pkt_id][a];              // Old contents
					model_bank[pkt_id][a] = d;
				end
				client_pkg::OP_ECHO: r = d;
				default: r = 8'h00;
			endcase
			model_ptr[pkt_id] = a + 4'd1;                  // Wraps at 16
		end
		pkt_pos++;
		return r;
	endfunction

	task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] act);
		n_checks++;
		if (act !== exp) begin
			errors++;
			$display("ERR %s expected %h got %h at %0t", name, exp, act, $time);
		end
	endtask

	// Compare on the falling edge, where odata is stable
	always @(negedge clk) begin
		while (stamp_q.size() > 0 && stamp_q[0] + client_pkg::LAT <= cyc) begin
			exp_byte = exp_q.pop_front();
			void'(stamp_q.pop_front());
			check_value("odata", exp_byte, odata);
			compared++;
		end
	end

	// One input cycle, driven on the falling edge
	task automatic drive_cycle(input logic s, input logic l, input logic [10:0] len,
			input logic [7:0] d);
		@(negedge clk);
		raw_s = s;
		raw_l = l;
		len_c = len;
		idata = d;
		exp_q.push_back(ref_reply(s & l, len, d));
		stamp_q.push_back(cyc);
		pushed++;
	endtask

	task automatic fill_data(input int n);
		for (int k = 0; k < n; k++) pkt_data[k] = 8'(rand_bits(8));
	endtask

	// Header, data bytes, then the single idle cycle
	task automatic send_packet(input int id, input int op, input int addr, input int ndata,
			input int len0);
		logic [10:0] len;
		len = 11'(len0);
		drive_cycle(1'b1, 1'b1, len, 8'(id));
		len--;
		drive_cycle(1'b1, 1'b1, len, 8'(op));
		len--;
		drive_cycle(1'b1, 1'b1, len, 8'(addr));
		len--;
		for (int k = 0; k < ndata; k++) begin
			drive_cycle(1'b1, 1'b1, len, pkt_data[k]);
			len--;
		end
		drive_cycle(1'b0, 1'b0, 11'd0, 8'h00);
	endtask

	function automatic int full_len(input int ndata);
		return ndata + client_pkg::HDR_LEN + 8;
	endfunction

	task automatic random_packet();
		int id;
		int op;
		int addr;
		int ndata;
		int len0;
		id = rand_bits(2);
		if (rand_bits(3) == 0) id = id + 4;           // Out of range now and then
		op = rand_bits(2);                            // 3 is an unknown opcode
		addr = rand_bits(8);
		ndata = 1 + rand_bits(5);
		len0 = full_len(ndata);
		if (rand_bits(3) == 0) len0 = rand_bits(4);  // Often below MIN_LEN
		fill_data(ndata);
		if (rand_bits(2) == 0) drive_cycle(1'b1, 1'b0, 11'(len0), 8'(rand_bits(8)));
		send_packet(id, op, addr, ndata, len0);
	endtask

	// Idle until every driven cycle has been compared
	task automatic drain_replies();
		int target;
		int waited;
		target = pushed;
		waited = 0;
		while (compared < target && waited <= 4 * client_pkg::LAT) begin
			drive_cycle(1'b0, 1'b0, 11'd0, 8'h00);
			waited++;
		end
		if (compared < target) begin
			errors++;
			$display("timeout: %0d expected replies were never compared", target - compared);
		end
	endtask

	task automatic report_test(input string name);
		n_tests++;
		$display("test %0d %s: %0d checks, %0d errors", n_tests, name,
			n_checks - test_checks, errors - test_errors);
		test_checks = n_checks;
		test_errors = errors;
	endtask

	initial begin
		lfsr_state = 32'hd245b336;
		reset = 1'b1;
		raw_s = 1'b0;
		raw_l = 1'b0;
		len_c = 11'd0;
		idata = 8'h00;
		{pushed, compared, n_checks, errors} = '0;
		{n_tests, test_checks, test_errors} = '0;
		prev_acc = 1'b0;
		pkt_pos = 0;
		pkt_rej = 1'b1;
		for (int c = 0; c < client_pkg::N_CLIENTS; c++) begin
			model_ptr[c] = 4'd0;
			for (int a = 0; a < client_pkg::BANK_DEPTH; a++) model_bank[c][a] = 8'h00;
		end
		repeat (5) @(negedge clk);
		reset = 1'b0;

		check_value("odata", 8'h00, odata);
		for (int c = 0; c < client_pkg::N_CLIENTS; c++) begin
			fill_data(16);
			send_packet(c, client_pkg::OP_READ, 0, 16, full_len(16));
		end
		drain_replies();
		report_test("reset and read zeros");

		// 20 bytes from address 10 wraps past 15
		for (int c = 0; c < client_pkg::N_CLIENTS; c++) begin
			fill_data(20);
			send_packet(c, client_pkg::OP_WRITE, 8'h10 * c + 10, 20, full_len(20));
			send_packet(c, client_pkg::OP_READ, 8'h0a, 20, full_len(20));
		end
		drain_replies();
		report_test("write then read");

		fill_data(12);
		send_packet(1, client_pkg::OP_ECHO, 5, 12, full_len(12));
		send_packet(2, 8'h07, 3, 6, full_len(6));
		send_packet(3, 8'hff, 0, 6, full_len(6));
		drain_replies();
		report_test("echo and unknown opcode");

		fill_data(8);
		send_packet(4, client_pkg::OP_WRITE, 0, 8, full_len(8));
		send_packet(8'hc1, client_pkg::OP_WRITE, 0, 8, full_len(8));  // Low bits name client 1
		send_packet(0, client_pkg::OP_WRITE, 0, 8, client_pkg::MIN_LEN - 1);
		for (int c = 0; c < client_pkg::N_CLIENTS; c++) begin
			send_packet(c, client_pkg::OP_READ, 0, 16, full_len(16));
		end
		drain_replies();
		report_test("rejected packets");

		for (int k = 0; k < 4; k++) drive_cycle(1'b1, 1'b0, 11'd20, 8'(rand_bits(8)));
		fill_data(5);
		send_packet(2, client_pkg::OP_WRITE, 7, 5, full_len(5));
		send_packet(2, client_pkg::OP_READ, 7, 5, full_len(5));
		send_packet(0, client_pkg::OP_ECHO, 1, 5, full_len(5));
		drain_replies();
		report_test("stray bytes and back-to-back packets");

		for (int p = 0; p < 40; p++) random_packet();
		drain_replies();
		report_test("random packets");

		$display("tests %0d checks %0d errors %0d", n_tests, n_checks, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// ==== all.f ====
common/client_pkg.sv
common/client_if.sv
rtl/client_steer.sv
reg_client/reg_client.sv
rtl/reply_merge.sv
rtl/client_hub.sv
verif/client_hub_chk.sv
verif/client_hub_tb.sv
